// File: Makefile
# Verilator build and run of the synaptic weight store testbench

VERILATOR ?= verilator
TOP       ?= tb_synapse_weight_mem
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= No errors

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+rtl
rtl/syn_addr_pkg.sv
rtl/weight_pkg.sv
rtl/weight_bank_if.sv
rtl/bank_router.sv
rtl/weight_bank.sv
rtl/recall_scaler.sv
rtl/learn_fifo.sv
rtl/synapse_weight_mem.sv
tb/tb_synapse_weight_mem.sv

// File: rtl/bank_router.sv
/*
 * Bank address decode for recall reads and weight writes,
 * write-back data forming and registered recall bank select
 */
module bank_router
	import syn_addr_pkg::*, weight_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           recall_rd_i,
	input  syn_addr_t      recall_addr_i,
	input  logic           wr_en_i,
	input  syn_addr_t      wr_addr_i,
	input  scaled_weight_t wr_data_i,
	input  logic           config_i,
	input  axon_scale_e    wb_scale_i,
	output bank_sel_t      recall_sel_o,
	weight_bank_if.router  banks [NUM_BANKS]
);

	bank_sel_t      rd_sel;
	bank_sel_t      wr_sel;
	bank_addr_t     rd_addr;
	bank_addr_t     wr_addr;
	scaled_weight_t shifted_back;
	weight_t        wb_data;

	assign rd_sel  = recall_addr_i[SYN_ADDR_BITS-1 -: BANK_SEL_BITS];
	assign wr_sel  = wr_addr_i[SYN_ADDR_BITS-1 -: BANK_SEL_BITS];
	assign rd_addr = recall_addr_i[BANK_ADDR_BITS-1:0];
	assign wr_addr = wr_addr_i[BANK_ADDR_BITS-1:0];

	// learned data goes back by the delayed head code
	assign shifted_back = wr_data_i >> scale_shift(wb_scale_i);
	assign wb_data = config_i ? wr_data_i[WEIGHT_BITS-1:0] : shifted_back[WEIGHT_BITS-1:0];

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_route
		assign banks[b].rd_en   = recall_rd_i && (rd_sel == bank_sel_t'(b));
		assign banks[b].rd_addr = rd_addr;
		assign banks[b].wr_en   = wr_en_i && (wr_sel == bank_sel_t'(b));
		assign banks[b].wr_addr = wr_addr;
		assign banks[b].wr_data = wb_data;
	end

	// select for the bank output in the cycle after the read
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			recall_sel_o <= '0;
		end
		else
		begin
			recall_sel_o <= rd_sel;
		end
	end

endmodule

// File: rtl/learn_fifo.sv
/*
 * Learning FIFO of scaled weights with their scaling codes,
 * plus the delay line feeding the head code to write-back
 */
module learn_fifo
	import weight_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  logic         clr_i,
	input  logic         push_i,
	input  learn_entry_t push_entry_i,
	input  logic         pop_i,
	output learn_entry_t head_o,
	output axon_scale_e  wb_scale_o
);

	localparam int DEPTH = 1 << FIFO_AW;

	learn_entry_t       mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               empty;
	logic               do_push;
	logic               do_pop;
	axon_scale_e        scale_line [LEARN_LATENCY];

	assign full  = (count == (FIFO_AW + 1)'(DEPTH));
	assign empty = (count == '0);

	// no back-pressure, overflow and underflow are silently dropped
	assign do_push = push_i && !full;
	assign do_pop  = pop_i && !empty;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop)
			begin
				count <= count + 1'b1;
			end
			else if (do_pop && !do_push)
			begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (do_push && !clr_i)
		begin
			mem[wr_ptr] <= push_entry_i;
		end
	end

	assign head_o = mem[rd_ptr];

	// head code enters at the top, leaves at stage 0
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < LEARN_LATENCY; i++)
			begin
				scale_line[i] <= SCALE_X1;
			end
		end
		else
		begin
			for (int i = 0; i < LEARN_LATENCY - 1; i++)
			begin
				scale_line[i] <= scale_line[i+1];
			end
			scale_line[LEARN_LATENCY-1] <= head_o.scale;
		end
	end

	assign wb_scale_o = scale_line[0];

endmodule

// File: rtl/recall_scaler.sv
/*
 * Recall output mux, sign extension and axon scaling,
 * push strobe and entry for the learning FIFO
 */
module recall_scaler
	import syn_addr_pkg::*, weight_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           recall_rd_i,
	input  bank_sel_t      recall_sel_i,
	input  axon_scale_e    scale_i,
	weight_bank_if.drain   banks [NUM_BANKS],
	output scaled_weight_t recall_data_o,
	output logic           push_o,
	output learn_entry_t   push_entry_o
);

	weight_t        bank_data [NUM_BANKS];
	weight_t        sel_data;
	scaled_weight_t extended;

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_drain
		assign bank_data[b] = banks[b].rd_data;
	end

	assign sel_data = bank_data[recall_sel_i];
	assign extended = {{(DSIZE - WEIGHT_BITS){sel_data[WEIGHT_BITS-1]}}, sel_data};

	// scaling follows scale_i of the current cycle
	assign recall_data_o = extended <<< scale_shift(scale_i);

	// data is valid one edge after the read strobe
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			push_o <= 1'b0;
		end
		else
		begin
			push_o <= recall_rd_i;
		end
	end

	assign push_entry_o = '{weight: recall_data_o, scale: scale_i};

endmodule

// File: rtl/snn_defines.svh
/*
 * Global widths and depths of the synaptic weight store,
 * learning FIFO depth and write-back latency
 */
`ifndef SNN_DEFINES_SVH
`define SNN_DEFINES_SVH

// synapse address split
`define SNN_NURN_BITS 8
`define SNN_AXON_BITS 8
`define SNN_NUM_BANKS 4

// weight widths
`define SNN_WEIGHT_BITS 12
`define SNN_DSIZE 16

// learning path
`define SNN_FIFO_AW 9
`define SNN_LEARN_LATENCY 4

`endif

// File: rtl/syn_addr_pkg.sv
/*
 * Synapse address types: full address, bank select, in-bank address
 */
package syn_addr_pkg;

	`include "snn_defines.svh"

	localparam int SYN_ADDR_BITS = `SNN_NURN_BITS + `SNN_AXON_BITS;
	localparam int NUM_BANKS = `SNN_NUM_BANKS;
	localparam int BANK_SEL_BITS = $clog2(NUM_BANKS);
	localparam int BANK_ADDR_BITS = SYN_ADDR_BITS - BANK_SEL_BITS;
	localparam int BANK_DEPTH = 1 << BANK_ADDR_BITS;

	// neuron index in the upper half, axon index in the lower half
	typedef logic [SYN_ADDR_BITS-1:0] syn_addr_t;

	// top address bits pick the bank
	typedef logic [BANK_SEL_BITS-1:0] bank_sel_t;

	// remaining bits index inside a bank
	typedef logic [BANK_ADDR_BITS-1:0] bank_addr_t;

endpackage

// File: rtl/synapse_weight_mem.sv
/*
 * Banked synaptic weight store top level: router, weight banks,
 * recall scaler and learning FIFO
 */
`include "snn_defines.svh"

module synapse_weight_mem
	import syn_addr_pkg::*, weight_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           start_i,

	input  logic           recall_rd_i,
	input  syn_addr_t      recall_addr_i,
	input  axon_scale_e    scale_i,
	output scaled_weight_t recall_data_o,

	input  logic           learn_rd_i,
	output scaled_weight_t learn_data_o,

	input  logic           wr_en_i,
	input  syn_addr_t      wr_addr_i,
	input  scaled_weight_t wr_data_i,
	input  logic           config_i
);

	bank_sel_t    recall_sel;
	axon_scale_e  wb_scale;
	logic         push;
	learn_entry_t push_entry;
	learn_entry_t head;

	weight_bank_if banks [`SNN_NUM_BANKS] ();

	bank_router u_bank_router (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.recall_rd_i   (recall_rd_i),
		.recall_addr_i (recall_addr_i),
		.wr_en_i       (wr_en_i),
		.wr_addr_i     (wr_addr_i),
		.wr_data_i     (wr_data_i),
		.config_i      (config_i),
		.wb_scale_i    (wb_scale),
		.recall_sel_o  (recall_sel),
		.banks         (banks)
	);

	for (genvar b = 0; b < `SNN_NUM_BANKS; b++)
	begin : g_bank
		weight_bank u_weight_bank (
			.clk_i (clk_i),
			.bank  (banks[b])
		);
	end

	recall_scaler u_recall_scaler (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.recall_rd_i   (recall_rd_i),
		.recall_sel_i  (recall_sel),
		.scale_i       (scale_i),
		.banks         (banks),
		.recall_data_o (recall_data_o),
		.push_o        (push),
		.push_entry_o  (push_entry)
	);

	// start of a new step empties the FIFO
	learn_fifo u_learn_fifo (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.clr_i        (start_i),
		.push_i       (push),
		.push_entry_i (push_entry),
		.pop_i        (learn_rd_i),
		.head_o       (head),
		.wb_scale_o   (wb_scale)
	);

	// the scaling code stays internal
	assign learn_data_o = head.weight;

endmodule

// File: rtl/weight_bank.sv
/*
 * One weight bank, synchronous write,
 * registered read address with asynchronous array read
 */
module weight_bank
	import syn_addr_pkg::*, weight_pkg::*;
(
	input logic         clk_i,
	weight_bank_if.bank bank
);

	weight_t    mem [BANK_DEPTH];
	bank_addr_t rd_addr_q;

	// address holds until the next read strobe
	always_ff @(posedge clk_i)
	begin
		if (bank.rd_en)
		begin
			rd_addr_q <= bank.rd_addr;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (bank.wr_en)
		begin
			mem[bank.wr_addr] <= bank.wr_data;
		end
	end

	assign bank.rd_data = mem[rd_addr_q];

endmodule

// File: rtl/weight_bank_if.sv
/*
 * Read and write signals of one weight bank
 * with router, bank and drain modports
 */
interface weight_bank_if
	import syn_addr_pkg::*, weight_pkg::*;
	;

	logic       rd_en;
	bank_addr_t rd_addr;
	logic       wr_en;
	bank_addr_t wr_addr;
	weight_t    wr_data;
	weight_t    rd_data;

	// address decode side
	modport router (
		output rd_en, rd_addr, wr_en, wr_addr, wr_data
	);

	modport bank (
		input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
		output rd_data
	);

	// recall output side
	modport drain (
		input rd_data
	);

endinterface

// File: rtl/weight_pkg.sv
/*
 * Weight types: stored weight, scaled weight, axon scaling code,
 * learning FIFO entry and the scaling shift lookup
 */
package weight_pkg;

	`include "snn_defines.svh"

	localparam int WEIGHT_BITS = `SNN_WEIGHT_BITS;
	localparam int DSIZE = `SNN_DSIZE;
	localparam int FIFO_AW = `SNN_FIFO_AW;
	localparam int LEARN_LATENCY = `SNN_LEARN_LATENCY;

	typedef logic signed [WEIGHT_BITS-1:0] weight_t;
	typedef logic signed [DSIZE-1:0] scaled_weight_t;

	// per-axon scaling code
	typedef enum logic [1:0] {
		SCALE_X1  = 2'd0,
		SCALE_X2  = 2'd1,
		SCALE_X4  = 2'd2,
		SCALE_X16 = 2'd3
	} axon_scale_e;

	// recalled value plus the code it was scaled with
	typedef struct packed {
		scaled_weight_t weight;
		axon_scale_e    scale;
	} learn_entry_t;

	// code 3 is a shift of four, not three
	function automatic int unsigned scale_shift(axon_scale_e s);
		case (s)
			SCALE_X2:  return 1;
			SCALE_X4:  return 2;
			SCALE_X16: return 4;
			default:   return 0;
		endcase
	endfunction

endpackage

// File: tb/tb_synapse_weight_mem.sv
/*
 * Testbench for the banked synaptic weight store: clock and reset,
 * expected-value model, check task, directed tests and watchdog
 */
module tb_synapse_weight_mem
	import syn_addr_pkg::*, weight_pkg::*;
	;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	// bus operations issued by all tests, each three clocks at most
	localparam int NUM_OPS = 60;
	localparam int OP_CYCLES = 3;
	localparam int TIMEOUT = 2 * (RESET_CYCLES + NUM_OPS * OP_CYCLES) * CLK_PERIOD;

	logic           clk;
	logic           rst_n;
	logic           start;
	logic           recall_rd;
	syn_addr_t      recall_addr;
	axon_scale_e    scale;
	scaled_weight_t recall_data;
	logic           learn_rd;
	scaled_weight_t learn_data;
	logic           wr_en;
	syn_addr_t      wr_addr;
	scaled_weight_t wr_data;
	logic           cfg_mode;

	int seed;
	int errors;
	int checks;

	synapse_weight_mem u_synapse_weight_mem (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.start_i       (start),
		.recall_rd_i   (recall_rd),
		.recall_addr_i (recall_addr),
		.scale_i       (scale),
		.recall_data_o (recall_data),
		.learn_rd_i    (learn_rd),
		.learn_data_o  (learn_data),
		.wr_en_i       (wr_en),
		.wr_addr_i     (wr_addr),
		.wr_data_i     (wr_data),
		.config_i      (cfg_mode)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// codes 0..2 shift by their value, code 3 jumps to four
	function automatic int code_shift(axon_scale_e s);
		return (s == SCALE_X16) ? 4 : int'(s);
	endfunction

	function automatic scaled_weight_t expect_recall(logic [11:0] w, axon_scale_e s);
		scaled_weight_t ext;
		ext = {{4{w[11]}}, w};
		return ext << code_shift(s);
	endfunction

	// learned data goes back right, low 12 bits kept
	function automatic logic [11:0] expect_stored(scaled_weight_t v, axon_scale_e s);
		scaled_weight_t shifted;
		shifted = v >> code_shift(s);
		return shifted[11:0];
	endfunction

	task automatic check_value(input string name, input scaled_weight_t expected,
		input scaled_weight_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic write_weight(input syn_addr_t addr, input scaled_weight_t data,
		input logic cfg);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		cfg_mode <= cfg;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// scale stays on the bus so the push one edge later takes it too
	task automatic recall_check(input string name, input syn_addr_t addr,
		input axon_scale_e s, input scaled_weight_t expected);
		@(posedge clk);
		recall_rd <= 1'b1;
		recall_addr <= addr;
		scale <= s;
		@(posedge clk);
		recall_rd <= 1'b0;
		@(negedge clk);
		check_value(name, expected, recall_data);
	endtask

	task automatic peek_check(input string name, input scaled_weight_t expected);
		@(negedge clk);
		check_value(name, expected, learn_data);
	endtask

	task automatic pop_check(input string name, input scaled_weight_t expected);
		peek_check(name, expected);
		@(posedge clk);
		learn_rd <= 1'b1;
		@(posedge clk);
		learn_rd <= 1'b0;
	endtask

	task automatic start_pulse;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic test_config_recall;
		logic [11:0] w;
		syn_addr_t addr;
		w = 12'($random(seed));
		addr = syn_addr_t'($random(seed));
		// upper data bits are ignored in config mode
		write_weight(addr, {4'h5, w}, 1'b1);
		recall_check("config_recall", addr, SCALE_X1, expect_recall(w, SCALE_X1));
	endtask

	task automatic test_axon_scaling;
		logic [11:0] w [2];
		syn_addr_t addr [2];
		axon_scale_e codes [3];
		codes = '{SCALE_X2, SCALE_X4, SCALE_X16};
		addr = '{16'h1234, 16'h5678};
		w[0] = {1'b0, 11'($random(seed))};
		w[1] = {1'b1, 11'($random(seed))};
		for (int i = 0; i < 2; i++)
		begin
			write_weight(addr[i], {4'h0, w[i]}, 1'b1);
		end
		for (int i = 0; i < 2; i++)
		begin
			for (int c = 0; c < 3; c++)
			begin
				recall_check("axon_scaling", addr[i], codes[c], expect_recall(w[i], codes[c]));
			end
		end
	endtask

	task automatic test_bank_independence;
		logic [11:0] w [NUM_BANKS];
		bank_addr_t low;
		low = bank_addr_t'($random(seed));
		// same in-bank address in every bank, all written before any recall
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			w[b] = 12'($random(seed));
			write_weight({bank_sel_t'(b), low}, {4'h0, w[b]}, 1'b1);
		end
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			recall_check("bank_independence", {bank_sel_t'(b), low}, SCALE_X1,
				expect_recall(w[b], SCALE_X1));
		end
	endtask

	task automatic test_fifo_order;
		logic [11:0] w [4];
		syn_addr_t addr [4];
		axon_scale_e codes [4];
		scaled_weight_t expected [4];
		codes = '{SCALE_X16, SCALE_X1, SCALE_X4, SCALE_X2};
		start_pulse();
		for (int i = 0; i < 4; i++)
		begin
			w[i] = 12'($random(seed));
			addr[i] = {bank_sel_t'(i), bank_addr_t'(14'h0a50 + i)};
			write_weight(addr[i], {4'h0, w[i]}, 1'b1);
		end
		for (int i = 0; i < 4; i++)
		begin
			expected[i] = expect_recall(w[i], codes[i]);
			recall_check("fifo_recall", addr[i], codes[i], expected[i]);
		end
		for (int i = 0; i < 3; i++)
		begin
			pop_check("fifo_order", expected[i]);
		end
		// one entry still queued, the clear drops it
		start_pulse();
		recall_check("fifo_clear", addr[0], SCALE_X2, expect_recall(w[0], SCALE_X2));
		peek_check("fifo_clear", expect_recall(w[0], SCALE_X2));
	endtask

	task automatic test_learned_writeback(input axon_scale_e s, input syn_addr_t addr,
		input scaled_weight_t value);
		logic [11:0] w;
		logic [11:0] stored;
		w = 12'($random(seed));
		stored = expect_stored(value, s);
		write_weight(addr, {4'h0, w}, 1'b1);
		start_pulse();
		// two entries, so the head keeps code s after the pop
		recall_check("learn_recall", addr, s, expect_recall(w, s));
		recall_check("learn_recall", addr, s, expect_recall(w, s));
		pop_check("learn_pop", expect_recall(w, s));
		repeat (LEARN_LATENCY + 1) @(posedge clk);
		write_weight(addr, value, 1'b0);
		recall_check("learned_writeback", addr, s, expect_recall(stored, s));
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		recall_rd = 1'b0;
		recall_addr = '0;
		scale = SCALE_X1;
		learn_rd = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		cfg_mode = 1'b0;
		seed = 32'h9c51c96d;
		errors = 0;
		checks = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		test_config_recall();
		test_axon_scaling();
		test_bank_independence();
		test_fifo_order();
		test_learned_writeback(SCALE_X2, 16'h3a11, 16'h8765);
		test_learned_writeback(SCALE_X4, 16'h7e02, 16'h2b7c);
		test_learned_writeback(SCALE_X16, 16'hc4f3, 16'hc3a0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT);
		$display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
		$display("Errors found");
		$finish;
	end

endmodule
